// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

	// ------------------------------
	// Sizes
	// ------------------------------
	localparam int XLEN       = 32;
	localparam int NREG       = 32;
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW    = 8;   // Word index bits

	// ------------------------------
	// Encodings
	// ------------------------------
	typedef enum logic [6:0] {
		OP_R      = 7'b0110011,
		OP_I_R    = 7'b0010011,
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
		ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_e;

	// Five conditions need a third bit
	typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_LTU} br_cnd_e;

	typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_PC_IMM} src_sel_e;

	typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_LINK, WB_MEM} wb_sel_e;

	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} mem_size_e;

	typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_e;

	// ------------------------------
	// Records
	// ------------------------------
	typedef struct packed {
		alu_op_e   alu_op;
		src_sel_e  src_sel;
		br_cnd_e   br_cnd;
		logic      order;          // Comparator operands swapped
		logic      we;
		logic      mem_val;
		logic      mem_wr;
		mem_size_e mem_size;
		logic      mem_unsigned;
		wb_sel_e   wb_sel;
		imm_fmt_e  imm_fmt;
		logic      rs1_used;
		logic      rs2_used;
	} ctrl_t;

	// No write, no memory request, no branch
	localparam ctrl_t CTRL_NOP = '{
		alu_op:       ALU_ADD,
		src_sel:      SRC_REG,
		br_cnd:       BR_NONE,
		order:        1'b0,
		we:           1'b0,
		mem_val:      1'b0,
		mem_wr:       1'b0,
		mem_size:     MEM_WORD,
		mem_unsigned: 1'b0,
		wb_sel:       WB_ALU,
		imm_fmt:      IMM_I,
		rs1_used:     1'b0,
		rs2_used:     1'b0
	};

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [31:0]     inst;
	} issue_t;

	typedef struct packed {
		ctrl_t           ctrl;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] rs1_val;
		logic [XLEN-1:0] rs2_val;
		logic [XLEN-1:0] imm;
		logic [4:0]      rd;
	} dec_exe_t;

	typedef struct packed {
		ctrl_t           ctrl;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] result;   // ALU value or memory address
		logic [XLEN-1:0] sdata;
		logic            taken;
		logic [4:0]      rd;
	} exe_mem_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [4:0]      rd;
		logic            we;
		logic [XLEN-1:0] wdata;
		logic            taken;
	} retire_t;

endpackage

`default_nettype wire

// File: logic/core_ctrl.sv
`default_nettype none

module core_ctrl (
	input  wire [31:0]     inst,
	output core_pkg::ctrl_t ctrl,
	output logic           illegal
);

	core_pkg::opcode_e opcode;
	logic [2:0]        funct3;
	logic [6:0]        funct7;

	assign opcode = core_pkg::opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// Shared funct3 map of R and I_R with funct7 zero
	function automatic core_pkg::alu_op_e base_op(input logic [2:0] f3);
		case (f3)
			3'b001:  return core_pkg::ALU_SLL;
			3'b010:  return core_pkg::ALU_SLT;
			3'b011:  return core_pkg::ALU_SLTU;
			3'b100:  return core_pkg::ALU_XOR;
			3'b101:  return core_pkg::ALU_SRL;
			3'b110:  return core_pkg::ALU_OR;
			3'b111:  return core_pkg::ALU_AND;
			default: return core_pkg::ALU_ADD;
		endcase
	endfunction

	always_comb begin
		ctrl = core_pkg::CTRL_NOP;
		illegal = 1'b0;
		case (opcode)
			core_pkg::OP_R: begin
				ctrl.we = 1'b1;
				ctrl.rs1_used = 1'b1;
				ctrl.rs2_used = 1'b1;
				case (funct7)
					7'b0000000: ctrl.alu_op = base_op(funct3);
					7'b0100000: begin
						case (funct3)
							3'b000:  ctrl.alu_op = core_pkg::ALU_SUB;
							3'b101:  ctrl.alu_op = core_pkg::ALU_SRA;
							default: illegal = 1'b1;   // AM slot included
						endcase
					end
					default: illegal = 1'b1;
				endcase
			end
			core_pkg::OP_I_R: begin
				ctrl.we = 1'b1;
				ctrl.rs1_used = 1'b1;
				ctrl.src_sel = core_pkg::SRC_IMM;
				ctrl.alu_op = base_op(funct3);
				case (funct3)
					3'b001: illegal = funct7 != 7'b0000000;
					3'b101: begin
						case (funct7)
							7'b0000000: ctrl.alu_op = core_pkg::ALU_SRL;
							7'b0100000: ctrl.alu_op = core_pkg::ALU_SRA;
							default:    illegal = 1'b1;
						endcase
					end
					default: ;                    // Plain immediate ops
				endcase
			end
			core_pkg::OP_LUI: begin
				ctrl.we = 1'b1;
				ctrl.wb_sel = core_pkg::WB_IMM;
				ctrl.imm_fmt = core_pkg::IMM_U;
			end
			core_pkg::OP_AUIPC: begin
				ctrl.we = 1'b1;
				ctrl.src_sel = core_pkg::SRC_PC_IMM;
				ctrl.imm_fmt = core_pkg::IMM_U;
			end
			core_pkg::OP_BRANCH: begin
				ctrl.rs1_used = 1'b1;
				ctrl.rs2_used = 1'b1;
				ctrl.imm_fmt = core_pkg::IMM_B;
				ctrl.order = funct3[0] && funct3[2];   // BGE, BGEU
				case (funct3)
					3'b000:         ctrl.br_cnd = core_pkg::BR_EQ;
					3'b001:         ctrl.br_cnd = core_pkg::BR_NE;
					3'b100, 3'b101: ctrl.br_cnd = core_pkg::BR_LT;
					3'b110, 3'b111: ctrl.br_cnd = core_pkg::BR_LTU;
					default:        illegal = 1'b1;
				endcase
			end
			core_pkg::OP_JAL: begin
				ctrl.we = 1'b1;
				ctrl.wb_sel = core_pkg::WB_LINK;
				ctrl.imm_fmt = core_pkg::IMM_J;
			end
			core_pkg::OP_JALR: begin
				ctrl.we = 1'b1;
				ctrl.rs1_used = 1'b1;
				ctrl.wb_sel = core_pkg::WB_LINK;
				illegal = funct3 != 3'b000;
			end
			core_pkg::OP_LOAD: begin
				ctrl.we = 1'b1;
				ctrl.rs1_used = 1'b1;
				ctrl.src_sel = core_pkg::SRC_IMM;
				ctrl.mem_val = 1'b1;
				ctrl.wb_sel = core_pkg::WB_MEM;
				ctrl.mem_unsigned = funct3[2];
				case (funct3)
					3'b000, 3'b100: ctrl.mem_size = core_pkg::MEM_BYTE;
					3'b001, 3'b101: ctrl.mem_size = core_pkg::MEM_HALF;
					3'b010:         ctrl.mem_size = core_pkg::MEM_WORD;
					default:        illegal = 1'b1;
				endcase
			end
			core_pkg::OP_STORE: begin
				ctrl.rs1_used = 1'b1;
				ctrl.rs2_used = 1'b1;
				ctrl.src_sel = core_pkg::SRC_IMM;
				ctrl.imm_fmt = core_pkg::IMM_S;
				ctrl.mem_val = 1'b1;
				ctrl.mem_wr = 1'b1;
				case (funct3)
					3'b000:  ctrl.mem_size = core_pkg::MEM_BYTE;
					3'b001:  ctrl.mem_size = core_pkg::MEM_HALF;
					3'b010:  ctrl.mem_size = core_pkg::MEM_WORD;
					default: illegal = 1'b1;
				endcase
			end
			default: illegal = 1'b1;
		endcase
		if (illegal) ctrl = core_pkg::CTRL_NOP;   // Back to the safe defaults
	end

endmodule

`default_nettype wire

// File: logic/core_reg_file.sv
`default_nettype none

module core_reg_file (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire [4:0]                 ra1,
	input  wire [4:0]                 ra2,
	output logic [core_pkg::XLEN-1:0] rd1,
	output logic [core_pkg::XLEN-1:0] rd2,
	input  wire                       we,
	input  wire [4:0]                 wa,
	input  wire [core_pkg::XLEN-1:0]  wd
);

	logic [core_pkg::XLEN-1:0] regs [core_pkg::NREG];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < core_pkg::NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;   // x0 never written
		end
	end

	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

	// x0 reads zero over any write history
	a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		ra1 == 5'd0 |-> rd1 == '0);

endmodule

`default_nettype wire

// File: logic/core_decode.sv
`default_nettype none

module core_decode (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       in_valid,
	output logic                      in_ready,
	input  wire core_pkg::issue_t     in_data,
	output logic [4:0]                ra1,
	output logic [4:0]                ra2,
	input  wire [core_pkg::XLEN-1:0]  rd1,
	input  wire [core_pkg::XLEN-1:0]  rd2,
	input  wire core_pkg::retire_t    exe_pend,
	input  wire core_pkg::retire_t    mem_pend,
	input  wire core_pkg::retire_t    ret_pend,
	output logic                      out_valid,
	input  wire                       out_ready,
	output core_pkg::dec_exe_t        out_data
);

	logic [31:0]               inst;
	core_pkg::ctrl_t           ctrl;
	core_pkg::ctrl_t           ctrl_issue;
	logic                      illegal;
	logic [core_pkg::XLEN-1:0] imm;
	logic                      rs1_busy;
	logic                      rs2_busy;
	logic                      stall;
	logic                      slot_free;

	function automatic logic pend_hit(input logic [4:0] rs, input core_pkg::retire_t p);
		return p.we && p.rd == rs;
	endfunction

	assign inst = in_data.inst;
	assign ra1 = inst[19:15];
	assign ra2 = inst[24:20];

	core_ctrl u_ctrl (
		.inst    (inst),
		.ctrl    (ctrl),
		.illegal (illegal)
	);

	always_comb begin
		case (ctrl.imm_fmt)
			core_pkg::IMM_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			core_pkg::IMM_B: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			core_pkg::IMM_U: imm = {inst[31:12], 12'b0};
			core_pkg::IMM_J: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			default:         imm = {{20{inst[31]}}, inst[31:20]};
		endcase
	end

	// ------------------------------
	// RAW interlock
	// ------------------------------
	assign rs1_busy = ra1 != 5'd0 &&
		(pend_hit(ra1, exe_pend) || pend_hit(ra1, mem_pend) || pend_hit(ra1, ret_pend));
	assign rs2_busy = ra2 != 5'd0 &&
		(pend_hit(ra2, exe_pend) || pend_hit(ra2, mem_pend) || pend_hit(ra2, ret_pend));
	assign stall = (ctrl.rs1_used && rs1_busy) || (ctrl.rs2_used && rs2_busy);

	assign slot_free = !out_valid || out_ready;
	assign in_ready = slot_free && !stall;

	always_comb begin
		ctrl_issue = ctrl;
		if (illegal) begin
			ctrl_issue.we = 1'b0;
			ctrl_issue.mem_val = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (slot_free) begin
			out_valid <= in_valid && !stall;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data.ctrl <= ctrl_issue;
			out_data.pc <= in_data.pc;
			out_data.rs1_val <= rd1;
			out_data.rs2_val <= rd2;
			out_data.imm <= imm;
			out_data.rd <= inst[11:7];
		end
	end

	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// File: logic/core_execute.sv
`default_nettype none

module core_execute (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    in_valid,
	output logic                   in_ready,
	input  wire core_pkg::dec_exe_t in_data,
	output logic                   out_valid,
	input  wire                    out_ready,
	output core_pkg::exe_mem_t     out_data
);

	logic [core_pkg::XLEN-1:0] op_a;
	logic [core_pkg::XLEN-1:0] op_b;
	logic [core_pkg::XLEN-1:0] alu;
	logic [core_pkg::XLEN-1:0] result;
	logic [core_pkg::XLEN-1:0] cmp_a;
	logic [core_pkg::XLEN-1:0] cmp_b;
	logic                      alu_lt;
	logic                      alu_ltu;
	logic                      eq;
	logic                      lt;
	logic                      ltu;
	logic                      taken;

	// ------------------------------
	// ALU
	// ------------------------------
	assign op_a = (in_data.ctrl.src_sel == core_pkg::SRC_PC_IMM) ? in_data.pc : in_data.rs1_val;
	assign op_b = (in_data.ctrl.src_sel == core_pkg::SRC_REG) ? in_data.rs2_val : in_data.imm;
	assign alu_lt = $signed(op_a) < $signed(op_b);
	assign alu_ltu = op_a < op_b;

	always_comb begin
		case (in_data.ctrl.alu_op)
			core_pkg::ALU_SUB:  alu = op_a - op_b;
			core_pkg::ALU_SLT:  alu = {{(core_pkg::XLEN-1){1'b0}}, alu_lt};
			core_pkg::ALU_SLTU: alu = {{(core_pkg::XLEN-1){1'b0}}, alu_ltu};
			core_pkg::ALU_AND:  alu = op_a & op_b;
			core_pkg::ALU_OR:   alu = op_a | op_b;
			core_pkg::ALU_XOR:  alu = op_a ^ op_b;
			core_pkg::ALU_SLL:  alu = op_a << op_b[4:0];
			core_pkg::ALU_SRL:  alu = op_a >> op_b[4:0];
			core_pkg::ALU_SRA:  alu = $signed(op_a) >>> op_b[4:0];
			default:            alu = op_a + op_b;   // Also load/store address
		endcase
	end

	// ------------------------------
	// Branch comparator
	// ------------------------------
	assign cmp_a = in_data.ctrl.order ? in_data.rs2_val : in_data.rs1_val;
	assign cmp_b = in_data.ctrl.order ? in_data.rs1_val : in_data.rs2_val;
	assign eq = cmp_a == cmp_b;
	assign lt = $signed(cmp_a) < $signed(cmp_b);
	assign ltu = cmp_a < cmp_b;

	// With the pair swapped, less-or-equal gives BGE and BGEU
	always_comb begin
		case (in_data.ctrl.br_cnd)
			core_pkg::BR_EQ:  taken = eq;
			core_pkg::BR_NE:  taken = !eq;
			core_pkg::BR_LT:  taken = lt || (in_data.ctrl.order && eq);
			core_pkg::BR_LTU: taken = ltu || (in_data.ctrl.order && eq);
			default:          taken = in_data.ctrl.wb_sel == core_pkg::WB_LINK;   // JAL, JALR
		endcase
	end

	always_comb begin
		case (in_data.ctrl.wb_sel)
			core_pkg::WB_IMM:  result = in_data.imm;
			core_pkg::WB_LINK: result = in_data.pc + 32'd4;
			default:           result = alu;
		endcase
	end

	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data.ctrl <= in_data.ctrl;
			out_data.pc <= in_data.pc;
			out_data.result <= result;
			out_data.sdata <= in_data.rs2_val;
			out_data.taken <= taken;
			out_data.rd <= in_data.rd;
		end
	end

endmodule

`default_nettype wire

// File: logic/core_mem.sv
`default_nettype none

module core_mem (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     in_valid,
	output logic                    in_ready,
	input  wire core_pkg::exe_mem_t in_data,
	output logic                    ret_valid,
	input  wire                     ret_ready,
	output core_pkg::retire_t       ret_data
);

	logic [core_pkg::XLEN-1:0]    ram [core_pkg::DMEM_WORDS];
	logic [core_pkg::DMEM_AW-1:0] idx;
	logic [1:0]                   off;
	logic                         acc_done;   // Read word captured for this entry
	logic                         leave;
	logic [core_pkg::XLEN-1:0]    rdata;
	logic [3:0]                   be;
	logic [core_pkg::XLEN-1:0]    wdata;
	logic [core_pkg::XLEN-1:0]    lane;
	logic [core_pkg::XLEN-1:0]    ld_val;

	assign idx = in_data.result[core_pkg::DMEM_AW+1:2];
	assign off = in_data.result[1:0];
	assign in_ready = acc_done && (!ret_valid || ret_ready);
	assign leave = in_valid && in_ready;

	// ------------------------------
	// Data RAM
	// ------------------------------
	always_comb begin
		case (in_data.ctrl.mem_size)
			core_pkg::MEM_BYTE: begin
				be = 4'b0001 << off;
				wdata = {4{in_data.sdata[7:0]}};
			end
			core_pkg::MEM_HALF: begin
				be = 4'b0011 << off;
				wdata = {2{in_data.sdata[15:0]}};
			end
			default: begin
				be = 4'b1111;
				wdata = in_data.sdata;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (in_valid && !acc_done) rdata <= ram[idx];
		if (leave && in_data.ctrl.mem_val && in_data.ctrl.mem_wr) begin
			for (int i = 0; i < 4; i++) begin
				if (be[i]) ram[idx][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

	// Load lane down to bit 0, then extend
	assign lane = rdata >> {off, 3'b000};

	always_comb begin
		case (in_data.ctrl.mem_size)
			core_pkg::MEM_BYTE: begin
				if (in_data.ctrl.mem_unsigned) ld_val = {24'b0, lane[7:0]};
				else ld_val = {{24{lane[7]}}, lane[7:0]};
			end
			core_pkg::MEM_HALF: begin
				if (in_data.ctrl.mem_unsigned) ld_val = {16'b0, lane[15:0]};
				else ld_val = {{16{lane[15]}}, lane[15:0]};
			end
			default: ld_val = rdata;
		endcase
	end

	// ------------------------------
	// Retire register
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_done <= 1'b0;
			ret_valid <= 1'b0;
		end else begin
			if (leave) acc_done <= 1'b0;
			else if (in_valid) acc_done <= 1'b1;
			if (!ret_valid || ret_ready) ret_valid <= leave;
		end
	end

	always_ff @(posedge clk) begin
		if (leave) begin
			ret_data.pc <= in_data.pc;
			ret_data.rd <= in_data.rd;
			ret_data.we <= in_data.ctrl.we;
			ret_data.wdata <= (in_data.ctrl.wb_sel == core_pkg::WB_MEM) ? ld_val : in_data.result;
			ret_data.taken <= in_data.taken;
		end
	end

	a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && in_data.ctrl.mem_val |->
			(in_data.ctrl.mem_size != core_pkg::MEM_HALF || !off[0]) &&
			(in_data.ctrl.mem_size != core_pkg::MEM_WORD || off == 2'b00));

endmodule

`default_nettype wire

// File: logic/core_top.sv
`default_nettype none

module core_top (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   in_valid,
	output logic                  in_ready,
	input  wire core_pkg::issue_t in_data,
	output logic                  ret_valid,
	input  wire                   ret_ready,
	output core_pkg::retire_t     ret_data
);

	logic                      de_valid;
	logic                      de_ready;
	core_pkg::dec_exe_t        de_data;
	logic                      em_valid;
	logic                      em_ready;
	core_pkg::exe_mem_t        em_data;
	logic [4:0]                ra1;
	logic [4:0]                ra2;
	logic [core_pkg::XLEN-1:0] rd1;
	logic [core_pkg::XLEN-1:0] rd2;
	logic                      rf_we;
	core_pkg::retire_t         exe_pend;
	core_pkg::retire_t         mem_pend;
	core_pkg::retire_t         ret_pend;

	// Destinations still in flight, one per stage register
	assign exe_pend = '{pc: de_data.pc, rd: de_data.rd, we: de_valid && de_data.ctrl.we,
		wdata: de_data.imm, taken: 1'b0};
	assign mem_pend = '{pc: em_data.pc, rd: em_data.rd, we: em_valid && em_data.ctrl.we,
		wdata: em_data.result, taken: em_data.taken};
	assign ret_pend = '{pc: ret_data.pc, rd: ret_data.rd, we: ret_valid && ret_data.we,
		wdata: ret_data.wdata, taken: ret_data.taken};

	assign rf_we = ret_valid && ret_ready && ret_data.we;   // Write at retire

	core_decode u_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.ra1       (ra1),
		.ra2       (ra2),
		.rd1       (rd1),
		.rd2       (rd2),
		.exe_pend  (exe_pend),
		.mem_pend  (mem_pend),
		.ret_pend  (ret_pend),
		.out_valid (de_valid),
		.out_ready (de_ready),
		.out_data  (de_data)
	);

	core_reg_file u_reg_file (
		.clk   (clk),
		.rst_n (rst_n),
		.ra1   (ra1),
		.ra2   (ra2),
		.rd1   (rd1),
		.rd2   (rd2),
		.we    (rf_we),
		.wa    (ret_data.rd),
		.wd    (ret_data.wdata)
	);

	core_execute u_execute (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (de_valid),
		.in_ready  (de_ready),
		.in_data   (de_data),
		.out_valid (em_valid),
		.out_ready (em_ready),
		.out_data  (em_data)
	);

	core_mem u_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (em_valid),
		.in_ready  (em_ready),
		.in_data   (em_data),
		.ret_valid (ret_valid),
		.ret_ready (ret_ready),
		.ret_data  (ret_data)
	);

endmodule

`default_nettype wire

// File: sim/core_tb.sv
`default_nettype none

module core_tb;

	logic              clk;
	logic              rst_n;
	logic              in_valid;
	logic              in_ready;
	core_pkg::issue_t  in_data;
	logic              ret_valid;
	logic              ret_ready;
	core_pkg::retire_t ret_data;

	core_pkg::issue_t  src_q[$];   // Instructions still to issue
	core_pkg::retire_t exp_q[$];   // Retire records still to see
	logic [31:0]       lfsr;
	int                n_lines;
	int                n_retired;

	core_top UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.ret_valid (ret_valid),
		.ret_ready (ret_ready),
		.ret_data  (ret_data)
	);

	always #5 clk = ~clk;

	// ------------------------------
	// Helpers
	// ------------------------------
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic next_bit(output logic b);
		b = lfsr[31];
		lfsr = lfsr_step(lfsr);
	endtask

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic fail_run(input string what);
		$display("ERROR at time %0t: %s", $time, what);
		abort_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic load_trace();
		int                fd;
		int                code;
		logic [63:0]       tag;
		logic [8*128-1:0]  rest;
		logic [31:0]       f_pc;
		logic [31:0]       f_inst;
		logic [31:0]       f_rd;
		logic [31:0]       f_we;
		logic [31:0]       f_wdata;
		logic [31:0]       f_taken;
		core_pkg::issue_t  iss;
		core_pkg::retire_t ret;
		fd = $fopen("sim/core_trace.txt", "r");
		if (fd == 0) begin
			fail_run("cannot open the trace file sim/core_trace.txt");
		end else begin
			while ($fscanf(fd, "%s", tag) == 1) begin
				if (tag == "#") begin
					code = $fgets(rest, fd);   // Comment line
				end else if (tag == "I") begin
					code = $fscanf(fd, "%h %h", f_pc, f_inst);
					if (code != 2) begin
						fail_run("malformed instruction line in the trace");
					end else begin
						iss.pc = f_pc;
						iss.inst = f_inst;
						src_q.push_back(iss);
						n_lines++;
					end
				end else if (tag == "R") begin
					code = $fscanf(fd, "%h %h %h %h %h", f_pc, f_rd, f_we, f_wdata, f_taken);
					if (code != 5) begin
						fail_run("malformed retire line in the trace");
					end else begin
						ret.pc = f_pc;
						ret.rd = f_rd[4:0];
						ret.we = f_we[0];
						ret.wdata = f_wdata;
						ret.taken = f_taken[0];
						exp_q.push_back(ret);
						n_lines++;
					end
				end else begin
					fail_run("unknown record tag in the trace");
				end
			end
			$fclose(fd);
		end
	endtask

	// rd and wdata only matter for a record that writes
	task automatic check_retire();
		core_pkg::retire_t want;
		if (exp_q.size() == 0) begin
			fail_run("instruction retired with no expected record left");
		end else begin
			want = exp_q.pop_front();
			n_retired++;
			check_value("ret_data.pc", ret_data.pc, want.pc);
			check_value("ret_data.we", ret_data.we, want.we);
			check_value("ret_data.taken", ret_data.taken, want.taken);
			if (want.we) begin
				check_value("ret_data.rd", ret_data.rd, want.rd);
				check_value("ret_data.wdata", ret_data.wdata, want.wdata);
			end
		end
	endtask

	// ------------------------------
	// Stimulus and checking
	// ------------------------------
	initial begin
		logic b;
		logic hold;    // Presented record not yet accepted
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		ret_ready = 1'b0;
		lfsr = 32'hd6112450;
		n_lines = 0;
		n_retired = 0;
		hold = 1'b0;
		load_trace();
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("in_ready", in_ready, 1'b1);
		check_value("ret_valid", ret_valid, 1'b0);
		while (exp_q.size() > 0) begin
			@(negedge clk);
			if (!hold && src_q.size() > 0) begin
				next_bit(b);
				in_valid = b;
				if (b) in_data = src_q[0];
				hold = b;
			end else if (!hold) begin
				in_valid = 1'b0;
			end
			next_bit(b);
			ret_ready = b;
			@(posedge clk);
			if (in_valid && in_ready) begin
				src_q.delete(0);
				hold = 1'b0;
			end
			if (ret_valid && ret_ready) check_retire();
		end
		// Quiet window to catch a duplicated record
		@(negedge clk);
		in_valid = 1'b0;
		ret_ready = 1'b1;
		repeat (10) begin
			@(posedge clk);
			if (ret_valid && ret_ready) check_retire();
		end
		if (src_q.size() > 0) begin
			fail_run("trace instructions left that never issued");
		end else begin
			$display("Retired %0d records", n_retired);
			$display("PASS: all tests");
			$finish;
		end
	end

	// Watchdog
	initial begin
		@(posedge rst_n);
		repeat (40 * n_lines + 100) @(posedge clk);
		fail_run("watchdog expired before the trace completed");
	end

endmodule

`default_nettype wire

// File: sim/core_trace.txt
# I pc inst
# R pc rd we wdata taken (rd and wdata checked only when we is 1)
# ALU and x0
I 00000100 ffb00093
R 00000100 01 1 fffffffb 0
I 00000104 00300113
R 00000104 02 1 00000003 0
I 00000108 401101b3
R 00000108 03 1 00000008 0
I 0000010c 4020d233
R 0000010c 04 1 ffffffff 0
I 00000110 0020a2b3
R 00000110 05 1 00000001 0
I 00000114 0020b333
R 00000114 06 1 00000000 0
I 00000118 00718013
R 00000118 00 1 0000000f 0
I 0000011c 003003b3
R 0000011c 07 1 00000008 0
I 00000120 00411493
R 00000120 09 1 00000030 0
I 00000124 12345537
R 00000124 0a 1 12345000 0
I 00000128 00001597
R 00000128 0b 1 00001128 0
# Branches and jumps
I 0000012c 00210463
R 0000012c 00 0 00000000 1
I 00000130 00211463
R 00000130 00 0 00000000 0
I 00000134 0020c463
R 00000134 00 0 00000000 1
I 00000138 0020d463
R 00000138 00 0 00000000 0
I 0000013c 0020e463
R 0000013c 00 0 00000000 0
I 00000140 0020f463
R 00000140 00 0 00000000 1
I 00000144 0071d463
R 00000144 00 0 00000000 1
I 00000148 0100066f
R 00000148 0c 1 0000014c 1
I 0000014c 000606e7
R 0000014c 0d 1 00000150 1
# Stores and loads
I 00000150 04000713
R 00000150 0e 1 00000040 0
I 00000154 876547b7
R 00000154 0f 1 87654000 0
I 00000158 32178793
R 00000158 0f 1 87654321 0
I 0000015c 00f72023
R 0000015c 00 0 00000000 0
I 00000160 00471123
R 00000160 00 0 00000000 0
I 00000164 009700a3
R 00000164 00 0 00000000 0
I 00000168 00072803
R 00000168 10 1 ffff3021 0
I 0000016c 00271883
R 0000016c 11 1 ffffffff 0
I 00000170 00075903
R 00000170 12 1 00003021 0
I 00000174 00170983
R 00000174 13 1 00000030 0
I 00000178 00374a03
R 00000178 14 1 000000ff 0
I 0000017c 00270a83
R 0000017c 15 1 ffffffff 0
# Illegal encodings
I 00000180 40209833
R 00000180 00 0 00000000 0
I 00000184 00273023
R 00000184 00 0 00000000 0
I 00000188 ffffffff
R 00000188 00 0 00000000 0
I 0000018c 00080b33
R 0000018c 16 1 ffff3021 0
I 00000190 00072b83
R 00000190 17 1 ffff3021 0

// File: verilog.f
logic/core_pkg.sv
logic/core_ctrl.sv
logic/core_reg_file.sv
logic/core_decode.sv
logic/core_execute.sv
logic/core_mem.sv
logic/core_top.sv
sim/core_tb.sv

// File: Bender.yml
package:
  name: rv32_core

sources:
  - logic/core_pkg.sv
  - logic/core_ctrl.sv
  - logic/core_reg_file.sv
  - logic/core_decode.sv
  - logic/core_execute.sv
  - logic/core_mem.sv
  - logic/core_top.sv
  - target: simulation
    files:
      - sim/core_tb.sv
